//--- src/limb_settings.svh
`ifndef LIMB_SETTINGS_SVH
`define LIMB_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// model sizing
////////////////////////////////////////////////////////////////////////

// number of motor units in the pool
// spike word is 16 bits so the pool stays at 16 or fewer
`define LIMB_NUM_UNITS 4

// waveform memory holds 2**8 length samples
`define LIMB_LEN_DEPTH_LOG2 8

// per-unit length offset, later units recruit at longer lengths
`define LIMB_RECRUIT_STEP 16'd2048

////////////////////////////////////////////////////////////////////////
// parameter values after reset_global
////////////////////////////////////////////////////////////////////////

// gain of 1.0 in 8.8 format
`define LIMB_RST_GAIN      16'h0100
`define LIMB_RST_THRESHOLD 16'h4000
`define LIMB_RST_TWITCH    16'h0200
`define LIMB_RST_REST_LEN  16'h2000
`define LIMB_RST_DECAY     4'd3
// tick every 8 clocks
`define LIMB_RST_TICK      16'd7

`endif

//--- src/limb_pkg.sv
package limb_pkg;

    ////////////////////////////////////////////////////////////////////////
    // host parameter set
    ////////////////////////////////////////////////////////////////////////

    // one field per trigger bit of the host bus
    typedef struct packed
    {
        // stretch receptor gain, 8.8 fixed point
        logic [15:0] spindle_gain;
        // membrane spike threshold
        // zero keeps every unit silent
        logic [15:0] fire_threshold;
        // force step added on each spike
        logic [15:0] twitch_size;
        // length below which the receptor gives no drive
        logic [15:0] rest_length;
        // force leak as a right shift
        logic [3:0]  force_decay;
        // clocks between ticks, minus one
        logic [15:0] tick_period;
    } limb_params_t;

    ////////////////////////////////////////////////////////////////////////
    // streaming records
    ////////////////////////////////////////////////////////////////////////

    // sample from the waveform player
    typedef struct packed
    {
        // one clock strobe per simulation step
        logic        tick;
        // unsigned muscle length
        logic [15:0] length;
    } length_sample_t;

    // registered result of one motor unit
    typedef struct packed
    {
        // one clock strobe, new state valid
        logic        step;
        // unit fired on the last step
        logic        spike;
        // twitch-sum force, unsigned
        logic [23:0] force_level;
    } unit_state_t;

endpackage

//--- src/param_bank.sv
`timescale 1ns/100ps
`include "limb_settings.svh"

module param_bank
(
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic [15:0]          trig,
    input  logic [15:0]          host_word,
    output limb_pkg::limb_params_t params
);

    ////////////////////////////////////////////////////////////////////////
    // receptor parameters
    ////////////////////////////////////////////////////////////////////////

    // trig bit 1 -> receptor gain
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            params.spindle_gain <= `LIMB_RST_GAIN;
        else if (trig[1])
            params.spindle_gain <= host_word;
    end

    // trig bit 4 -> rest length
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            params.rest_length <= `LIMB_RST_REST_LEN;
        else if (trig[4])
            params.rest_length <= host_word;
    end

    ////////////////////////////////////////////////////////////////////////
    // neuron and force parameters
    ////////////////////////////////////////////////////////////////////////

    // trig bit 2 -> spike threshold
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            params.fire_threshold <= `LIMB_RST_THRESHOLD;
        else if (trig[2])
            params.fire_threshold <= host_word;
    end

    // trig bit 3 -> twitch size
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            params.twitch_size <= `LIMB_RST_TWITCH;
        else if (trig[3])
            params.twitch_size <= host_word;
    end

    // trig bit 5 -> decay shift, low nibble only
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            params.force_decay <= `LIMB_RST_DECAY;
        else if (trig[5])
            params.force_decay <= host_word[3:0];
    end

    // trig bit 7 -> tick period
    // bits 0, 6 and 8..15 are unused here
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            params.tick_period <= `LIMB_RST_TICK;
        else if (trig[7])
            params.tick_period <= host_word;
    end

endmodule

//--- src/length_player.sv
`timescale 1ns/100ps
`include "limb_settings.svh"

module length_player
(
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   reset_sim,
    input  logic                   pipe_write,
    input  logic [15:0]            pipe_data,
    input  logic [15:0]            tick_period,
    output limb_pkg::length_sample_t sample
);

    localparam int ADDR_W = `LIMB_LEN_DEPTH_LOG2;
    localparam int DEPTH  = 1 << ADDR_W;

    // waveform store
    logic [15:0]     wave_mem [DEPTH];
    // number of stored samples, saturates at DEPTH
    logic [ADDR_W:0] sample_count;
    logic [ADDR_W-1:0] wr_ptr;
    logic            mem_full;
    logic            wr_en;

    // replay side
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0] rd_next;
    logic [15:0]     tick_cnt;
    logic            run;
    logic            tick;

    ////////////////////////////////////////////////////////////////////////
    // pipe write side
    ////////////////////////////////////////////////////////////////////////

    // next free slot is the sample count itself
    assign wr_ptr   = sample_count[ADDR_W-1:0];
    // top bit of the count only sets once every slot is used
    assign mem_full = sample_count[ADDR_W];
    // writes past the end are dropped
    assign wr_en    = pipe_write && !mem_full;

    always_ff @(posedge ep50trig)
    begin
        if (wr_en)
            wave_mem[wr_ptr] <= pipe_data;
    end

    // count survives reset_sim, only reset_global empties the store
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            sample_count <= '0;
        else if (wr_en)
            sample_count <= sample_count + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////
    // tick timebase
    ////////////////////////////////////////////////////////////////////////

    // free running only with data and outside a sim reset
    assign run  = (sample_count != '0) && !reset_sim;
    assign tick = run && (tick_cnt == 16'd0);

    // down counter, held at the period while idle
    // so the first tick lands tick_period+1 clocks after start
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            tick_cnt <= 16'd0;
        else if (!run || tick)
            tick_cnt <= tick_period;
        else
            tick_cnt <= tick_cnt - 16'd1;
    end

    ////////////////////////////////////////////////////////////////////////
    // replay pointer
    ////////////////////////////////////////////////////////////////////////

    assign rd_next = {1'b0, rd_ptr} + 1'b1;

    // wrap against the count seen this cycle
    // a write in the same cycle counts from the next tick on
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            rd_ptr <= '0;
        else if (reset_sim)
            rd_ptr <= '0;
        else if (tick)
        begin
            if (rd_next >= sample_count)
                rd_ptr <= '0;
            else
                rd_ptr <= rd_next[ADDR_W-1:0];
        end
    end

    // async read, sample at the pointer during the tick cycle
    assign sample.tick   = tick;
    assign sample.length = wave_mem[rd_ptr];

endmodule

//--- src/motor_unit.sv
`timescale 1ns/100ps
`include "limb_settings.svh"

module motor_unit
#(
    parameter integer UNIT_INDEX = 0
)
(
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   reset_sim,
    input  limb_pkg::length_sample_t sample,
    input  limb_pkg::limb_params_t   params,
    output limb_pkg::unit_state_t    state
);

    // recruitment offset grows with unit index
    localparam int unsigned RECRUIT_OFFSET = UNIT_INDEX * `LIMB_RECRUIT_STEP;

    // receptor
    logic [32:0] knee_len;
    logic [15:0] excess;
    logic [31:0] drive_prod;
    logic [15:0] drive;

    // membrane
    logic [23:0] membrane_q;
    logic [24:0] memb_sum;
    logic [23:0] memb_sat;
    logic [23:0] memb_next;
    logic        fire;

    // force
    logic [23:0] force_q;
    logic [23:0] force_leak;
    logic [15:0] twitch_add;
    logic [24:0] force_sum;
    logic [23:0] force_next;

    logic        step_q;
    logic        spike_q;

    ////////////////////////////////////////////////////////////////////////
    // stretch receptor drive
    ////////////////////////////////////////////////////////////////////////

    // length where this unit starts to see stretch
    assign knee_len = {17'd0, params.rest_length} + 33'(RECRUIT_OFFSET);

    // floored at zero below the knee
    // knee fits in 16 bits whenever length exceeds it
    assign excess = ({17'd0, sample.length} > knee_len) ?
                    (sample.length - knee_len[15:0]) : 16'd0;

    // 16 x 8.8 product, back to integer
    assign drive_prod = excess * params.spindle_gain;
    assign drive      = (|drive_prod[31:24]) ? 16'hFFFF : drive_prod[23:8];

    ////////////////////////////////////////////////////////////////////////
    // integrate and fire
    ////////////////////////////////////////////////////////////////////////

    assign memb_sum = {1'b0, membrane_q} + {9'd0, drive};
    assign memb_sat = memb_sum[24] ? 24'hFF_FFFF : memb_sum[23:0];

    // zero threshold disables firing
    assign fire = (params.fire_threshold != 16'd0) &&
                  (memb_sat >= {8'd0, params.fire_threshold});

    // subtractive reset keeps the residue
    assign memb_next = fire ? (memb_sat - {8'd0, params.fire_threshold}) : memb_sat;

    ////////////////////////////////////////////////////////////////////////
    // twitch force
    ////////////////////////////////////////////////////////////////////////

    // leak first, then add this step's twitch
    assign force_leak = force_q - (force_q >> params.force_decay);
    assign twitch_add = fire ? params.twitch_size : 16'd0;
    assign force_sum  = {1'b0, force_leak} + {9'd0, twitch_add};
    assign force_next = force_sum[24] ? 24'hFF_FFFF : force_sum[23:0];

    // state advances only on a tick
    // step follows the tick by one clock
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            step_q     <= 1'b0;
            spike_q    <= 1'b0;
            membrane_q <= 24'd0;
            force_q    <= 24'd0;
        end
        else
        begin
            step_q <= sample.tick;
            if (reset_sim)
            begin
                spike_q    <= 1'b0;
                membrane_q <= 24'd0;
                force_q    <= 24'd0;
            end
            else if (sample.tick)
            begin
                spike_q    <= fire;
                membrane_q <= memb_next;
                force_q    <= force_next;
            end
        end
    end

    assign state.step        = step_q;
    assign state.spike       = spike_q;
    assign state.force_level = force_q;

endmodule

//--- src/unit_collector.sv
`timescale 1ns/100ps
`include "limb_settings.svh"

module unit_collector
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  limb_pkg::unit_state_t states [`LIMB_NUM_UNITS],
    output logic [31:0]           total_force,
    output logic [15:0]           spike_word,
    output logic                  force_valid
);

    logic [31:0] force_total;
    logic [15:0] spike_bits;

    ////////////////////////////////////////////////////////////////////////
    // combine the pool
    ////////////////////////////////////////////////////////////////////////

    // 16 units of 24 bits fit well inside 32
    // unit i lands in spike bit i, unused bits stay zero
    always_comb
    begin
        force_total = 32'd0;
        spike_bits  = 16'd0;
        for (int i = 0; i < `LIMB_NUM_UNITS; i++)
        begin
            force_total   = force_total + 32'(states[i].force_level);
            spike_bits[i] = states[i].spike;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////

    // all units step together, unit 0 stands for the pool
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            total_force <= 32'd0;
            spike_word  <= 16'd0;
            force_valid <= 1'b0;
        end
        else
        begin
            force_valid <= states[0].step;
            if (states[0].step)
            begin
                total_force <= force_total;
                spike_word  <= spike_bits;
            end
        end
    end

endmodule

//--- src/limb_sim_top.sv
`timescale 1ns/100ps
`include "limb_settings.svh"

module limb_sim_top
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic [15:0] trig,
    input  logic [15:0] host_word,
    input  logic        pipe_write,
    input  logic [15:0] pipe_data,
    input  logic        reset_sim,
    output logic [31:0] total_force,
    output logic [15:0] spike_word,
    output logic        force_valid,
    output logic [15:0] length_now
);

    import limb_pkg::*;

    limb_params_t   params;
    length_sample_t sample;
    unit_state_t    unit_states [`LIMB_NUM_UNITS];

    ////////////////////////////////////////////////////////////////////////
    // host parameters and waveform
    ////////////////////////////////////////////////////////////////////////

    param_bank u_param_bank
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .trig         (trig),
        .host_word    (host_word),
        .params       (params)
    );

    length_player u_length_player
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .tick_period  (params.tick_period),
        .sample       (sample)
    );

    // last ticked length for the host
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            length_now <= 16'd0;
        else if (sample.tick)
            length_now <= sample.length;
    end

    ////////////////////////////////////////////////////////////////////////
    // motor unit pool
    ////////////////////////////////////////////////////////////////////////

    // same sample to every unit, index sets recruitment order
    for (genvar i = 0; i < `LIMB_NUM_UNITS; i++)
    begin : g_unit
        motor_unit #(.UNIT_INDEX(i)) u_motor_unit
        (
            .ep50trig     (ep50trig),
            .reset_global (reset_global),
            .reset_sim    (reset_sim),
            .sample       (sample),
            .params       (params),
            .state        (unit_states[i])
        );
    end

    unit_collector u_unit_collector
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .states       (unit_states),
        .total_force  (total_force),
        .spike_word   (spike_word),
        .force_valid  (force_valid)
    );

endmodule

//--- tb/limb_checker.sv
`timescale 1ns/100ps
`include "limb_settings.svh"

module limb_checker
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic [15:0] trig,
    input  logic [15:0] host_word,
    input  logic        pipe_write,
    input  logic [15:0] pipe_data,
    input  logic        reset_sim,
    input  logic [31:0] total_force,
    input  logic [15:0] spike_word,
    input  logic        force_valid,
    input  logic [15:0] length_now,
    input  logic        test_end,
    input  logic [2:0]  test_id,
    output int          check_count,
    output int          error_count
);

    import limb_pkg::*;

    localparam int     NUM_UNITS = `LIMB_NUM_UNITS;
    localparam int     DEPTH     = 1 << `LIMB_LEN_DEPTH_LOG2;
    localparam longint RECRUIT   = longint'(`LIMB_RECRUIT_STEP);
    localparam longint DRIVE_MAX = 64'hFFFF;
    localparam longint LEVEL_MAX = 64'hFF_FFFF;

    // one expected collector result
    typedef struct packed
    {
        logic [31:0] due;
        logic [31:0] total;
        logic [15:0] spikes;
    } expect_t;

    // model of the parameter bank and waveform store
    limb_params_t mp;
    logic [15:0]  wave [DEPTH];
    logic [8:0]   count;
    logic [7:0]   ptr;
    logic [15:0]  wait_cnt;
    logic [31:0]  edge_n;
    logic [15:0]  exp_len_now;

    // unit state and results still in the pipeline
    logic [23:0]  memb [NUM_UNITS];
    logic [23:0]  frc [NUM_UNITS];
    expect_t      pending [$];

    // held collector outputs
    logic [31:0]  last_total;
    logic [15:0]  last_spike;

    int checks      = 0;
    int cmp_errors  = 0;
    int check_mark  = 0;
    int error_mark  = 0;

    assign check_count = checks;
    assign error_count = cmp_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "idle after reset";
            3'd2: return "replay order and wrap";
            3'd3: return "random parameters";
            3'd4: return "parameter change mid-run";
            3'd5: return "sim reset";
            3'd6: return "tick every cycle";
            default: return "unnamed";
        endcase
    endfunction

    task automatic clear_units();
        for (int u = 0; u < NUM_UNITS; u++)
        begin
            memb[u] = 24'd0;
            frc[u]  = 24'd0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // receptor, neuron and twitch rules for one tick
    ////////////////////////////////////////////////////////////////////

    task automatic step_units(input logic [15:0] len, input logic [31:0] due_edge);
        longint  knee;
        longint  excess;
        longint  drive;
        longint  level;
        longint  force_v;
        logic    fire;
        expect_t e;
        e.due    = due_edge;
        e.total  = 32'd0;
        e.spikes = 16'd0;
        for (int u = 0; u < NUM_UNITS; u++)
        begin
            // later units need more stretch
            knee   = longint'(mp.rest_length) + RECRUIT * longint'(u);
            excess = 0;
            if (longint'(len) > knee)
                excess = longint'(len) - knee;
            // 8.8 gain
            drive = (excess * longint'(mp.spindle_gain)) >> 8;
            if (drive > DRIVE_MAX)
                drive = DRIVE_MAX;
            level = longint'(memb[u]) + drive;
            if (level > LEVEL_MAX)
                level = LEVEL_MAX;
            fire = (mp.fire_threshold != 16'd0) && (level >= longint'(mp.fire_threshold));
            if (fire)
                level = level - longint'(mp.fire_threshold);
            // leak, then twitch
            force_v = longint'(frc[u]) - (longint'(frc[u]) >> mp.force_decay);
            if (fire)
                force_v = force_v + longint'(mp.twitch_size);
            if (force_v > LEVEL_MAX)
                force_v = LEVEL_MAX;
            memb[u]     = level[23:0];
            frc[u]      = force_v[23:0];
            e.total     = e.total + {8'd0, frc[u]};
            e.spikes[u] = fire;
        end
        pending.push_back(e);
    endtask

    ////////////////////////////////////////////////////////////////////
    // model advanced on every clock from the sampled inputs
    ////////////////////////////////////////////////////////////////////

    always @(posedge ep50trig or posedge reset_global)
    begin : model
        logic run;
        logic tick;
        if (reset_global)
        begin
            mp.spindle_gain   = `LIMB_RST_GAIN;
            mp.fire_threshold = `LIMB_RST_THRESHOLD;
            mp.twitch_size    = `LIMB_RST_TWITCH;
            mp.rest_length    = `LIMB_RST_REST_LEN;
            mp.force_decay    = `LIMB_RST_DECAY;
            mp.tick_period    = `LIMB_RST_TICK;
            count       = 9'd0;
            ptr         = 8'd0;
            wait_cnt    = 16'd0;
            edge_n      = 32'd0;
            exp_len_now = 16'd0;
            pending.delete();
            clear_units();
        end
        else
        begin
            edge_n = edge_n + 32'd1;
            // one tick per tick_period+1 clocks while samples exist
            run  = (count != 9'd0) && !reset_sim;
            tick = run && (wait_cnt == 16'd0);
            if (!run || tick)
                wait_cnt = mp.tick_period;
            else
                wait_cnt = wait_cnt - 16'd1;
            if (reset_sim)
            begin
                ptr = 8'd0;
                clear_units();
            end
            else if (tick)
            begin
                exp_len_now = wave[ptr];
                // collector output lands one clock after the units
                step_units(wave[ptr], edge_n + 32'd1);
                if ({1'b0, ptr} + 9'd1 >= count)
                    ptr = 8'd0;
                else
                    ptr = ptr + 8'd1;
            end
            // writes after the tick, so a new count waits for the next one
            if (pipe_write && !count[8])
            begin
                wave[count[7:0]] = pipe_data;
                count = count + 9'd1;
            end
            if (trig[1])
                mp.spindle_gain = host_word;
            if (trig[2])
                mp.fire_threshold = host_word;
            if (trig[3])
                mp.twitch_size = host_word;
            if (trig[4])
                mp.rest_length = host_word;
            if (trig[5])
                mp.force_decay = host_word[3:0];
            if (trig[7])
                mp.tick_period = host_word;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // compare on the falling edge once outputs settle
    ////////////////////////////////////////////////////////////////////

    always @(negedge ep50trig)
    begin : compare
        logic    due;
        expect_t exp_e;
        if (reset_global)
        begin
            last_total = 32'd0;
            last_spike = 16'd0;
        end
        else
        begin
            due = (pending.size() > 0) && (pending[0].due == edge_n);
            if (due)
            begin
                exp_e      = pending.pop_front();
                last_total = exp_e.total;
                last_spike = exp_e.spikes;
                checks++;
                if (!force_valid)
                begin
                    $display("force_valid did not pulse at %0t after a tick", $time);
                    cmp_errors++;
                end
            end
            else if (force_valid)
            begin
                $display("force_valid pulsed at %0t with no tick before it", $time);
                cmp_errors++;
            end
            // outputs hold between pulses
            if (total_force !== last_total)
            begin
                $display("Mismatch at %0t: total_force %0h, expected %0h",
                         $time, total_force, last_total);
                cmp_errors++;
            end
            if (spike_word !== last_spike)
            begin
                $display("Mismatch at %0t: spike_word %0h, expected %0h",
                         $time, spike_word, last_spike);
                cmp_errors++;
            end
            if (length_now !== exp_len_now)
            begin
                $display("Mismatch at %0t: length_now %0h, expected %0h",
                         $time, length_now, exp_len_now);
                cmp_errors++;
            end
        end
    end

    // one line per finished test
    always @(posedge ep50trig)
    begin
        if (test_end)
        begin
            $display("test %0d %s: %0d checks, %0d errors", test_id, test_name(test_id),
                     checks - check_mark, cmp_errors - error_mark);
            check_mark = checks;
            error_mark = cmp_errors;
        end
    end

endmodule

//--- tb/tb_limb_sim.sv
`timescale 1ns/100ps

module tb_limb_sim;

    localparam logic [31:0] SEED = 32'hec8cfddc;
    localparam int RESET_CYCLES  = 16;
    // ticks times tick_period+1 for tests 2 to 6
    localparam int RUN_CYCLES    = 80 * 6 + 300 * 6 + 100 * 6 + (20 + 100 * 6) + 100 * 1;
    // idle test, sample writes, parameter loads
    localparam int SETUP_CYCLES  = 200 + 2 * 40 + 2 * 20;
    localparam int MARGIN        = 1000;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + SETUP_CYCLES + RUN_CYCLES + MARGIN;

    logic        ep50trig = 1'b0;
    logic        reset_global;
    logic [15:0] trig;
    logic [15:0] host_word;
    logic        pipe_write;
    logic [15:0] pipe_data;
    logic        reset_sim;
    logic [31:0] total_force;
    logic [15:0] spike_word;
    logic        force_valid;
    logic [15:0] length_now;

    logic        test_end;
    logic [2:0]  test_id;
    int          check_count;
    int          error_count;
    int          cycle_count = 0;
    logic [31:0] rng;

    always #5 ep50trig = ~ep50trig;

    limb_sim_top UUT
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .trig         (trig),
        .host_word    (host_word),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .reset_sim    (reset_sim),
        .total_force  (total_force),
        .spike_word   (spike_word),
        .force_valid  (force_valid),
        .length_now   (length_now)
    );

    limb_checker u_checker
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .trig         (trig),
        .host_word    (host_word),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .reset_sim    (reset_sim),
        .total_force  (total_force),
        .spike_word   (spike_word),
        .force_valid  (force_valid),
        .length_now   (length_now),
        .test_end     (test_end),
        .test_id      (test_id),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    ////////////////////////////////////////////////////////////////////
    // helpers called on a falling edge
    ////////////////////////////////////////////////////////////////////

    // xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_param(input int bit_index, input logic [15:0] value);
        trig      = 16'd1 << bit_index;
        host_word = value;
        @(negedge ep50trig);
        trig = 16'd0;
    endtask

    task automatic write_sample(input logic [15:0] value);
        pipe_write = 1'b1;
        pipe_data  = value;
        @(negedge ep50trig);
        pipe_write = 1'b0;
    endtask

    // count result strobes until n have arrived
    task automatic wait_results(input int n);
        int seen;
        seen = 0;
        while (seen < n)
        begin
            @(negedge ep50trig);
            if (force_valid)
                seen++;
        end
    endtask

    task automatic finish_test();
        test_end = 1'b1;
        @(negedge ep50trig);
        test_end = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////

    initial
    begin
        reset_global = 1'b1;
        trig         = 16'd0;
        host_word    = 16'd0;
        pipe_write   = 1'b0;
        pipe_data    = 16'd0;
        reset_sim    = 1'b0;
        test_end     = 1'b0;
        test_id      = 3'd0;
        rng          = SEED;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;

        // empty store so nothing may tick
        test_id = 3'd1;
        repeat (200) @(negedge ep50trig);
        finish_test();

        // load with ticks held off, then replay twice round
        test_id   = 3'd2;
        reset_sim = 1'b1;
        load_param(7, 16'd5);
        for (int i = 0; i < 40; i++)
        begin
            rng = next_random(rng);
            write_sample(rng[15:0]);
        end
        reset_sim = 1'b0;
        wait_results(80);
        finish_test();

        // gain up to about 16x, threshold kept nonzero
        test_id = 3'd3;
        rng = next_random(rng);
        load_param(1, {4'd0, rng[11:0]});
        rng = next_random(rng);
        load_param(2, rng[15:0] | 16'h0100);
        rng = next_random(rng);
        load_param(3, rng[15:0]);
        rng = next_random(rng);
        load_param(4, {1'b0, rng[14:0]});
        rng = next_random(rng);
        load_param(5, rng[15:0]);
        wait_results(300);
        finish_test();

        // new threshold and gain while ticking
        test_id = 3'd4;
        wait_results(50);
        rng = next_random(rng);
        load_param(2, rng[15:0] | 16'h0040);
        rng = next_random(rng);
        load_param(1, {5'd0, rng[10:0]});
        wait_results(50);
        finish_test();

        test_id   = 3'd5;
        reset_sim = 1'b1;
        repeat (20) @(negedge ep50trig);
        reset_sim = 1'b0;
        wait_results(100);
        finish_test();

        // back to back ticks with two results in flight
        test_id = 3'd6;
        load_param(7, 16'd0);
        wait_results(100);
        finish_test();

        // the compare on the last falling edge settles first
        @(posedge ep50trig);
        $display("6 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // run length guard
    always @(posedge ep50trig)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+src
src/limb_pkg.sv
src/param_bank.sv
src/length_player.sv
src/motor_unit.sv
src/unit_collector.sv
src/limb_sim_top.sv
tb/limb_checker.sv
tb/tb_limb_sim.sv

//--- Makefile
# Verilator build and run of the limb model testbench

VERILATOR ?= verilator
TOP       ?= tb_limb_sim
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= No errors

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
